/* hdl/core_pkg.sv */
package core_pkg;

  typedef logic [31:0] word_t;   // data, pc and instruction word
  typedef logic [4:0]  reg_id_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // major opcodes of the supported subset
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD  = 3'b000;  // also SUB, ADDI, BEQ
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010;  // LW / SW

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // beq x0, x0, 0 -- spins in place, used as halt
  localparam word_t HALT_INSTR = 32'h0000_0063;

endpackage

/* hdl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              advance,
  input  logic              id_valid,
  input  core_pkg::word_t   id_pc,
  input  core_pkg::word_t   id_rs1_data,
  input  core_pkg::word_t   id_rs2_data,
  input  core_pkg::word_t   id_imm,
  input  core_pkg::reg_id_t id_rs1,
  input  core_pkg::reg_id_t id_rs2,
  input  core_pkg::reg_id_t id_rd,
  input  core_pkg::alu_op_e id_alu_op,
  input  logic              id_use_imm,
  input  logic              id_reg_write,
  input  logic              id_mem_read,
  input  logic              id_mem_write,
  input  logic              id_is_branch,
  input  logic              wb_reg_write,
  input  core_pkg::reg_id_t wb_rd,
  input  core_pkg::word_t   wb_data,
  output core_pkg::reg_id_t ex_rd,
  output logic              ex_mem_read,
  output logic              br_taken,
  output core_pkg::word_t   br_target,
  output logic              mem_valid,
  output core_pkg::word_t   mem_pc,
  output core_pkg::reg_id_t mem_rd,
  output core_pkg::word_t   mem_result,
  output core_pkg::word_t   mem_store_data,
  output logic              mem_reg_write,
  output logic              mem_mem_read,
  output logic              mem_mem_write
);

  logic              ex_valid;
  core_pkg::word_t   ex_pc;
  core_pkg::word_t   ex_rs1_data;
  core_pkg::word_t   ex_rs2_data;
  core_pkg::word_t   ex_imm;
  core_pkg::reg_id_t ex_rs1;
  core_pkg::reg_id_t ex_rs2;
  core_pkg::alu_op_e ex_alu_op;
  logic              ex_use_imm;
  logic              ex_reg_write;
  logic              ex_mem_write;
  logic              ex_is_branch;
  logic              id_live;
  core_pkg::word_t   op_a, op_b, alu_b, alu_res;

  assign id_live = id_valid & ~br_taken;  // younger instr dies on a taken branch

  // mem-stage result first, loads excluded (stall covers them)
  assign op_a = (mem_reg_write && !mem_mem_read && mem_rd == ex_rs1) ? mem_result :
                (wb_reg_write && wb_rd == ex_rs1) ? wb_data : ex_rs1_data;
  assign op_b = (mem_reg_write && !mem_mem_read && mem_rd == ex_rs2) ? mem_result :
                (wb_reg_write && wb_rd == ex_rs2) ? wb_data : ex_rs2_data;

  assign alu_b = ex_use_imm ? ex_imm : op_b;

  always_comb begin
    case (ex_alu_op)
      core_pkg::ALU_SUB: alu_res = op_a - alu_b;
      core_pkg::ALU_AND: alu_res = op_a & alu_b;
      core_pkg::ALU_OR:  alu_res = op_a | alu_b;
      core_pkg::ALU_XOR: alu_res = op_a ^ alu_b;
      core_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
      default:           alu_res = op_a + alu_b;  // add, load/store address
    endcase
  end

  assign br_taken  = ex_is_branch && op_a == op_b;
  assign br_target = ex_pc + ex_imm;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      ex_valid      <= 1'b0;
      ex_reg_write  <= 1'b0;
      ex_mem_read   <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_is_branch  <= 1'b0;
      mem_valid     <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
    end else if (advance) begin
      ex_valid      <= id_live;
      ex_reg_write  <= id_live & id_reg_write;
      ex_mem_read   <= id_live & id_mem_read;
      ex_mem_write  <= id_live & id_mem_write;
      ex_is_branch  <= id_live & id_is_branch;
      mem_valid     <= ex_valid;
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (advance) begin
      ex_pc          <= id_pc;
      ex_rs1_data    <= id_rs1_data;
      ex_rs2_data    <= id_rs2_data;
      ex_imm         <= id_imm;
      ex_rs1         <= id_rs1;
      ex_rs2         <= id_rs2;
      ex_rd          <= id_rd;
      ex_alu_op      <= id_alu_op;
      ex_use_imm     <= id_use_imm;
      mem_pc         <= ex_pc;
      mem_rd         <= ex_rd;
      mem_result     <= alu_res;
      mem_store_data <= op_b;
    end
  end

endmodule

/* hdl/fetch_decode_stage.sv */
`timescale 1ns/10ps

module fetch_decode_stage (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              advance,
  input  core_pkg::word_t   fetch_instr,
  input  logic              br_taken,
  input  core_pkg::word_t   br_target,
  input  core_pkg::reg_id_t ex_rd,
  input  logic              ex_mem_read,
  input  logic              wb_reg_write,
  input  core_pkg::reg_id_t wb_rd,
  input  core_pkg::word_t   wb_data,
  output core_pkg::word_t   fetch_addr,
  output logic              id_valid,
  output core_pkg::word_t   id_pc,
  output core_pkg::word_t   id_rs1_data,
  output core_pkg::word_t   id_rs2_data,
  output core_pkg::word_t   id_imm,
  output core_pkg::reg_id_t id_rs1,
  output core_pkg::reg_id_t id_rs2,
  output core_pkg::reg_id_t id_rd,
  output core_pkg::alu_op_e id_alu_op,
  output logic              id_use_imm,
  output logic              id_reg_write,
  output logic              id_mem_read,
  output logic              id_mem_write,
  output logic              id_is_branch
);

  core_pkg::word_t pc;
  core_pkg::word_t fd_instr;
  core_pkg::word_t fd_pc;
  logic            fd_valid;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            legal_reg;
  logic            is_reg, is_imm, is_load, is_store, is_beq;
  logic            uses_rs1, uses_rs2;
  logic            load_use;
  core_pkg::word_t regs [32];

  assign fetch_addr = pc;
  assign id_pc      = fd_pc;
  assign opcode     = fd_instr[6:0];
  assign funct3     = fd_instr[14:12];
  assign funct7     = fd_instr[31:25];
  assign id_rd      = fd_instr[11:7];
  assign id_rs1     = fd_instr[19:15];
  assign id_rs2     = fd_instr[24:20];

  always_comb begin
    legal_reg = 1'b1;
    id_alu_op = core_pkg::ALU_ADD;
    if (funct7 == core_pkg::F7_SUB && funct3 == core_pkg::F3_ADD) begin
      id_alu_op = core_pkg::ALU_SUB;
    end else if (funct7 == core_pkg::F7_BASE) begin
      case (funct3)
        core_pkg::F3_ADD: id_alu_op = core_pkg::ALU_ADD;
        core_pkg::F3_AND: id_alu_op = core_pkg::ALU_AND;
        core_pkg::F3_OR:  id_alu_op = core_pkg::ALU_OR;
        core_pkg::F3_XOR: id_alu_op = core_pkg::ALU_XOR;
        core_pkg::F3_SLT: id_alu_op = core_pkg::ALU_SLT;
        default:          legal_reg = 1'b0;
      endcase
    end else begin
      legal_reg = 1'b0;
    end
    if (opcode != core_pkg::OP_REG) id_alu_op = core_pkg::ALU_ADD;  // address / addi
    if (opcode == core_pkg::OP_BRANCH) id_alu_op = core_pkg::ALU_SUB;
  end

  // unsupported encodings fall through as no-ops
  assign is_reg   = opcode == core_pkg::OP_REG && legal_reg;
  assign is_imm   = opcode == core_pkg::OP_IMM && funct3 == core_pkg::F3_ADD;
  assign is_load  = opcode == core_pkg::OP_LOAD && funct3 == core_pkg::F3_WORD;
  assign is_store = opcode == core_pkg::OP_STORE && funct3 == core_pkg::F3_WORD;
  assign is_beq   = opcode == core_pkg::OP_BRANCH && funct3 == core_pkg::F3_ADD;

  always_comb begin
    case (opcode)
      core_pkg::OP_STORE:  id_imm = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
      core_pkg::OP_BRANCH: id_imm = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7],
                                     fd_instr[30:25], fd_instr[11:8], 1'b0};
      default:             id_imm = {{20{fd_instr[31]}}, fd_instr[31:20]};
    endcase
  end

  assign id_use_imm   = is_imm | is_load | is_store;
  assign id_reg_write = (is_reg | is_imm | is_load) && id_rd != '0;  // x0 never written
  assign id_mem_read  = is_load;
  assign id_mem_write = is_store;
  assign id_is_branch = is_beq;

  assign uses_rs1 = is_reg | is_imm | is_load | is_store | is_beq;
  assign uses_rs2 = is_reg | is_store | is_beq;
  assign load_use = fd_valid && ex_mem_read && ex_rd != '0 &&
                    ((uses_rs1 && id_rs1 == ex_rd) || (uses_rs2 && id_rs2 == ex_rd));
  assign id_valid = fd_valid & ~load_use;  // bubble on load-use

  // register file, same-cycle writeback read through
  assign id_rs1_data = (id_rs1 == '0) ? '0 :
                       (wb_reg_write && wb_rd == id_rs1) ? wb_data : regs[id_rs1];
  assign id_rs2_data = (id_rs2 == '0) ? '0 :
                       (wb_reg_write && wb_rd == id_rs2) ? wb_data : regs[id_rs2];

  always_ff @(posedge sys_clk) begin
    if (advance && wb_reg_write) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      pc       <= '0;
      fd_valid <= 1'b0;
    end else if (advance) begin
      if (br_taken) begin
        pc       <= br_target;
        fd_valid <= 1'b0;  // flush
      end else if (!load_use) begin
        fd_valid <= start;
        if (start) pc <= pc + 32'd4;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (advance && !br_taken && !load_use) begin
      fd_instr <= fetch_instr;
      fd_pc    <= pc;
    end
  end

endmodule

/* hdl/memory_writeback_stage.sv */
`timescale 1ns/10ps

module memory_writeback_stage #(
  parameter int DMEM_WORDS = 64
) (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              advance,
  input  logic              mem_valid,
  input  core_pkg::word_t   mem_pc,
  input  core_pkg::reg_id_t mem_rd,
  input  core_pkg::word_t   mem_result,
  input  core_pkg::word_t   mem_store_data,
  input  logic              mem_reg_write,
  input  logic              mem_mem_read,
  input  logic              mem_mem_write,
  output logic              wb_valid,
  output core_pkg::word_t   wb_pc,
  output core_pkg::reg_id_t wb_rd,
  output logic              wb_reg_write,
  output core_pkg::word_t   wb_data
);

  localparam int AW = $clog2(DMEM_WORDS);

  core_pkg::word_t dmem [DMEM_WORDS];
  logic [29:0]     word_idx;
  logic            in_range;
  core_pkg::word_t load_data;

  assign word_idx  = mem_result[31:2];
  assign in_range  = word_idx < 30'(DMEM_WORDS);
  assign load_data = in_range ? dmem[word_idx[AW-1:0]] : '0;  // out of range reads zero

  always_ff @(posedge sys_clk) begin
    if (advance && mem_mem_write && in_range) begin
      dmem[word_idx[AW-1:0]] <= mem_store_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      wb_valid     <= 1'b0;
      wb_reg_write <= 1'b0;
    end else if (advance) begin
      wb_valid     <= mem_valid;
      wb_reg_write <= mem_reg_write;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (advance) begin
      wb_pc   <= mem_pc;
      wb_rd   <= mem_rd;
      wb_data <= mem_mem_read ? load_data : mem_result;
    end
  end

endmodule

/* hdl/program_loader.sv */
`timescale 1ns/10ps

module program_loader #(
  parameter int IMEM_WORDS = 64
) (
  input  logic            sys_clk,
  input  logic            rst_n,
  input  logic            load_valid,
  input  core_pkg::word_t load_addr,   // word index
  input  core_pkg::word_t load_data,
  input  logic            run,
  input  core_pkg::word_t fetch_addr,
  output core_pkg::word_t fetch_instr,
  output logic            start
);

  localparam int AW = $clog2(IMEM_WORDS);

  core_pkg::word_t imem [IMEM_WORDS];
  logic [29:0]     fetch_idx;

  assign fetch_idx = fetch_addr[31:2];

  // anything past the program reads the halt loop
  assign fetch_instr = (fetch_idx < 30'(IMEM_WORDS)) ? imem[fetch_idx[AW-1:0]]
                                                     : core_pkg::HALT_INSTR;

  always_ff @(posedge sys_clk) begin
    if (load_valid && !start && load_addr < 32'(IMEM_WORDS)) begin
      imem[load_addr[AW-1:0]] <= load_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      start <= 1'b0;
    end else if (run) begin
      start <= 1'b1;  // sticky until reset
    end
  end

endmodule

/* hdl/retire_port.sv */
`timescale 1ns/10ps

module retire_port #(
  parameter int RETIRE_CREDITS = 4
) (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              wb_valid,
  input  core_pkg::word_t   wb_pc,
  input  core_pkg::reg_id_t wb_rd,
  input  logic              wb_reg_write,
  input  core_pkg::word_t   wb_data,
  input  logic              credit_return,
  output logic              advance,
  output logic              retire_valid,
  output core_pkg::word_t   retire_pc,
  output core_pkg::reg_id_t retire_rd,
  output logic              retire_reg_write,
  output core_pkg::word_t   retire_data
);

  localparam int CW = $clog2(RETIRE_CREDITS + 1);

  logic [CW-1:0] credits;

  // no credit left means the whole core stalls
  assign advance      = credits != '0;
  assign retire_valid = advance & wb_valid;

  assign retire_pc        = wb_pc;
  assign retire_rd        = wb_rd;
  assign retire_reg_write = retire_valid & wb_reg_write;
  assign retire_data      = wb_data;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      credits <= CW'(RETIRE_CREDITS);
    end else begin
      credits <= credits - CW'(retire_valid) + CW'(credit_return);  // both may hit at once
    end
  end

endmodule

/* hdl/riscv_core.sv */
`timescale 1ns/10ps

module riscv_core #(
  parameter int IMEM_WORDS     = 64,
  parameter int DMEM_WORDS     = 64,
  parameter int RETIRE_CREDITS = 4
) (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              load_valid,
  input  core_pkg::word_t   load_addr,
  input  core_pkg::word_t   load_data,
  input  logic              run,
  input  logic              credit_return,
  output logic              retire_valid,
  output core_pkg::word_t   retire_pc,
  output core_pkg::reg_id_t retire_rd,
  output logic              retire_reg_write,
  output core_pkg::word_t   retire_data
);

  logic              start, advance;
  core_pkg::word_t   fetch_addr, fetch_instr;
  logic              id_valid, id_use_imm, id_reg_write, id_mem_read;
  logic              id_mem_write, id_is_branch;
  core_pkg::word_t   id_pc, id_rs1_data, id_rs2_data, id_imm;
  core_pkg::reg_id_t id_rs1, id_rs2, id_rd;
  core_pkg::alu_op_e id_alu_op;
  core_pkg::reg_id_t ex_rd;
  logic              ex_mem_read, br_taken;
  core_pkg::word_t   br_target;
  logic              mem_valid, mem_reg_write, mem_mem_read, mem_mem_write;
  core_pkg::word_t   mem_pc, mem_result, mem_store_data;
  core_pkg::reg_id_t mem_rd;
  logic              wb_valid, wb_reg_write;
  core_pkg::word_t   wb_pc, wb_data;
  core_pkg::reg_id_t wb_rd;

  program_loader #(.IMEM_WORDS(IMEM_WORDS)) program_loader_i (
    .sys_clk(sys_clk), .rst_n(rst_n),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .run(run), .fetch_addr(fetch_addr), .fetch_instr(fetch_instr), .start(start)
  );

  fetch_decode_stage fetch_decode_stage_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .start(start), .advance(advance),
    .fetch_instr(fetch_instr), .br_taken(br_taken), .br_target(br_target),
    .ex_rd(ex_rd), .ex_mem_read(ex_mem_read),
    .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_data(wb_data),
    .fetch_addr(fetch_addr), .id_valid(id_valid), .id_pc(id_pc),
    .id_rs1_data(id_rs1_data), .id_rs2_data(id_rs2_data), .id_imm(id_imm),
    .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rd(id_rd), .id_alu_op(id_alu_op),
    .id_use_imm(id_use_imm), .id_reg_write(id_reg_write), .id_mem_read(id_mem_read),
    .id_mem_write(id_mem_write), .id_is_branch(id_is_branch)
  );

  execute_stage execute_stage_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .advance(advance),
    .id_valid(id_valid), .id_pc(id_pc), .id_rs1_data(id_rs1_data),
    .id_rs2_data(id_rs2_data), .id_imm(id_imm), .id_rs1(id_rs1), .id_rs2(id_rs2),
    .id_rd(id_rd), .id_alu_op(id_alu_op), .id_use_imm(id_use_imm),
    .id_reg_write(id_reg_write), .id_mem_read(id_mem_read),
    .id_mem_write(id_mem_write), .id_is_branch(id_is_branch),
    .wb_reg_write(wb_reg_write), .wb_rd(wb_rd), .wb_data(wb_data),
    .ex_rd(ex_rd), .ex_mem_read(ex_mem_read), .br_taken(br_taken), .br_target(br_target),
    .mem_valid(mem_valid), .mem_pc(mem_pc), .mem_rd(mem_rd), .mem_result(mem_result),
    .mem_store_data(mem_store_data), .mem_reg_write(mem_reg_write),
    .mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write)
  );

  memory_writeback_stage #(.DMEM_WORDS(DMEM_WORDS)) memory_writeback_stage_i (
    .sys_clk(sys_clk), .rst_n(rst_n), .advance(advance),
    .mem_valid(mem_valid), .mem_pc(mem_pc), .mem_rd(mem_rd), .mem_result(mem_result),
    .mem_store_data(mem_store_data), .mem_reg_write(mem_reg_write),
    .mem_mem_read(mem_mem_read), .mem_mem_write(mem_mem_write),
    .wb_valid(wb_valid), .wb_pc(wb_pc), .wb_rd(wb_rd),
    .wb_reg_write(wb_reg_write), .wb_data(wb_data)
  );

  retire_port #(.RETIRE_CREDITS(RETIRE_CREDITS)) retire_port_i (
    .sys_clk(sys_clk), .rst_n(rst_n),
    .wb_valid(wb_valid), .wb_pc(wb_pc), .wb_rd(wb_rd),
    .wb_reg_write(wb_reg_write), .wb_data(wb_data), .credit_return(credit_return),
    .advance(advance), .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_reg_write(retire_reg_write), .retire_data(retire_data)
  );

endmodule

/* riscv_core.f */
hdl/core_pkg.sv
hdl/program_loader.sv
hdl/fetch_decode_stage.sv
hdl/execute_stage.sv
hdl/memory_writeback_stage.sv
hdl/retire_port.sv
hdl/riscv_core.sv
tb/riscv_core_tb.sv

/* tb/riscv_core_tb.sv */
`timescale 1ns/10ps

module riscv_core_tb;

  localparam int IMEM_WORDS      = 64;
  localparam int DMEM_WORDS      = 64;
  localparam int RETIRE_CREDITS  = 4;
  localparam int N_INSTR         = 40;
  localparam logic [31:0] HALT_PC = N_INSTR * 4;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  // loading, reset, then per instruction fill + stall + credit delay
  localparam int WATCHDOG_CYCLES = IMEM_WORDS + 10 + N_INSTR * (4 + 1 + 8) + 100;

  logic              sys_clk;
  logic              rst_n;
  logic              load_valid;
  core_pkg::word_t   load_addr;
  core_pkg::word_t   load_data;
  logic              run;
  logic              credit_return;
  logic              retire_valid;
  core_pkg::word_t   retire_pc;
  core_pkg::reg_id_t retire_rd;
  logic              retire_reg_write;
  core_pkg::word_t   retire_data;

  logic [31:0] lfsr;
  logic [31:0] prog [IMEM_WORDS];
  logic [31:0] mregs [32];
  logic [31:0] model_mem [DMEM_WORDS];
  logic [31:0] exp_pc [N_INSTR + 1];
  logic [31:0] exp_data [N_INSTR + 1];
  logic [4:0]  exp_rd [N_INSTR + 1];
  logic        exp_wr [N_INSTR + 1];
  int          n_exp;
  int          exp_idx;
  int          avail;   // credits the DUT holds, as seen from here
  int          owed;    // credits received and not yet returned
  int          delay;
  bit          run_issued;
  bit          halt_seen;

  riscv_core #(
    .IMEM_WORDS(IMEM_WORDS),
    .DMEM_WORDS(DMEM_WORDS),
    .RETIRE_CREDITS(RETIRE_CREDITS)
  ) dut_i (
    .sys_clk(sys_clk), .rst_n(rst_n),
    .load_valid(load_valid), .load_addr(load_addr), .load_data(load_data),
    .run(run), .credit_return(credit_return),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_reg_write(retire_reg_write), .retire_data(retire_data)
  );

  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    int          b;
    val = '0;
    for (b = 0; b < n; b++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic logic [31:0] reg_instr(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, core_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] imm_instr(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] store_instr(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, core_pkg::F3_WORD, imm[4:0], core_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] branch_instr(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], core_pkg::OP_BRANCH};
  endfunction

  task automatic build_program();
    int         i;
    int         k;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] kind, sel;
    for (i = 0; i < 7; i++) begin  // give x1..x7 known values
      prog[i] = imm_instr(12'(take_bits(12)), 5'd0, 3'b000, 5'(i + 1), core_pkg::OP_IMM);
    end
    for (i = 7; i < 11; i++) begin  // and the four data words
      prog[i] = store_instr(12'((i - 7) * 4), 5'(take_bits(3)), 5'd0);
    end
    for (i = 11; i < N_INSTR; i++) begin
      rd   = 5'(take_bits(3));
      rs1  = 5'(take_bits(3));
      rs2  = 5'(take_bits(3));
      kind = 3'(take_bits(3));
      case (kind)
        3'd3: prog[i] = imm_instr(12'(take_bits(12)), rs1, 3'b000, rd, core_pkg::OP_IMM);
        3'd4: prog[i] = imm_instr(12'(take_bits(2) * 4), 5'd0, 3'b010, rd, core_pkg::OP_LOAD);
        3'd5: prog[i] = store_instr(12'(take_bits(2) * 4), rs2, 5'd0);
        3'd6: begin
          if (take_bits(1) != 0) rs2 = rs1;  // makes taken branches likely
          k = 1 + int'(take_bits(3));
          if (i + k > N_INSTR) k = N_INSTR - i;
          prog[i] = branch_instr(13'(k * 4), rs2, rs1);
        end
        default: begin
          sel = 3'(take_bits(3));
          case (sel)
            3'd1:    prog[i] = reg_instr(7'b0100000, 3'b000, rd, rs1, rs2);  // sub
            3'd2:    prog[i] = reg_instr(7'b0000000, 3'b111, rd, rs1, rs2);
            3'd3:    prog[i] = reg_instr(7'b0000000, 3'b110, rd, rs1, rs2);
            3'd4:    prog[i] = reg_instr(7'b0000000, 3'b100, rd, rs1, rs2);
            3'd5:    prog[i] = reg_instr(7'b0000000, 3'b010, rd, rs1, rs2);  // slt
            default: prog[i] = reg_instr(7'b0000000, 3'b000, rd, rs1, rs2);
          endcase
        end
      endcase
    end
    prog[N_INSTR] = branch_instr(13'd0, 5'd0, 5'd0);  // halt loop
    for (i = N_INSTR + 1; i < IMEM_WORDS; i++) begin
      prog[i] = imm_instr(12'(i), 5'd0, 3'b000, 5'd0, core_pkg::OP_IMM);
    end
  endtask

  // plain in-order execution of the same program
  task automatic run_model();
    logic [31:0] pc, instr, next_pc, a, b, val, imm_i, imm_s, imm_b;
    logic [4:0]  rd;
    logic        wr;
    bit          done;
    for (int r = 0; r < 32; r++) mregs[r] = '0;
    pc    = '0;
    n_exp = 0;
    done  = 1'b0;
    while (!done) begin
      instr   = prog[pc[31:2]];
      rd      = instr[11:7];
      a       = mregs[instr[19:15]];
      b       = mregs[instr[24:20]];
      imm_i   = {{20{instr[31]}}, instr[31:20]};
      imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      wr      = 1'b0;
      val     = '0;
      next_pc = pc + 4;
      case (instr[6:0])
        core_pkg::OP_REG: begin
          wr = 1'b1;
          case ({instr[30], instr[14:12]})
            4'b1000: val = a - b;
            4'b0111: val = a & b;
            4'b0110: val = a | b;
            4'b0100: val = a ^ b;
            4'b0010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: val = a + b;
          endcase
        end
        core_pkg::OP_IMM: begin
          wr  = 1'b1;
          val = a + imm_i;
        end
        core_pkg::OP_LOAD: begin
          wr  = 1'b1;
          val = model_mem[(a + imm_i) >> 2];
        end
        core_pkg::OP_STORE: model_mem[(a + imm_s) >> 2] = b;
        core_pkg::OP_BRANCH: if (a == b) next_pc = pc + imm_b;
        default: ;
      endcase
      wr = wr && rd != 5'd0;
      if (wr) mregs[rd] = val;
      exp_pc[n_exp]   = pc;
      exp_wr[n_exp]   = wr;
      exp_rd[n_exp]   = rd;
      exp_data[n_exp] = val;
      n_exp++;
      done = pc == HALT_PC;
      pc   = next_pc;
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED time %0t: %s actual %h expected %h", $time, name, actual, expected);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s (time %0t)", reason, $time);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // retire monitor, sampled mid-cycle
  always @(negedge sys_clk) begin
    if (retire_valid === 1'b1) begin
      if (!run_issued) begin
        abort_run("an instruction retired before run");
      end else if (avail == 0) begin
        abort_run("retire_valid pulsed while no credit was left");
      end else if (exp_idx >= n_exp) begin
        abort_run("more instructions retired than the model executed");
      end else begin
        compare_value("retire_pc", retire_pc, exp_pc[exp_idx]);
        compare_value("retire_reg_write", 32'(retire_reg_write), 32'(exp_wr[exp_idx]));
        if (exp_wr[exp_idx]) begin
          compare_value("retire_rd", 32'(retire_rd), 32'(exp_rd[exp_idx]));
          compare_value("retire_data", retire_data, exp_data[exp_idx]);
        end
        avail--;
        owed++;
        if (exp_pc[exp_idx] == HALT_PC) halt_seen = 1'b1;
        exp_idx++;
      end
    end
  end

  // credit consumer
  always @(posedge sys_clk) begin
    if (!rst_n) begin
      credit_return <= 1'b0;
    end else begin
      if (credit_return) avail++;  // dut counts it at this edge
      if (owed > 0 && delay == 0) begin
        credit_return <= 1'b1;
        owed--;
        delay = int'(take_bits(3));
      end else begin
        credit_return <= 1'b0;
        if (delay > 0) delay--;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
    abort_run("watchdog expired, the core stopped retiring");
  end

  initial begin
    rst_n         = 1'b0;
    load_valid    = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    run           = 1'b0;
    credit_return = 1'b0;
    avail         = RETIRE_CREDITS;
    owed          = 0;
    delay         = 0;
    exp_idx       = 0;
    run_issued    = 1'b0;
    halt_seen     = 1'b0;
    lfsr          = 32'ha9aeee65;
    build_program();
    run_model();
    repeat (2) @(posedge sys_clk);
    rst_n <= 1'b1;
    @(negedge sys_clk);
    compare_value("retire_valid", 32'(retire_valid), 32'd0);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      @(posedge sys_clk);
      load_valid <= 1'b1;
      load_addr  <= 32'(i);
      load_data  <= prog[i];
    end
    @(posedge sys_clk);
    load_valid <= 1'b0;
    run        <= 1'b1;
    run_issued = 1'b1;
    @(posedge sys_clk);
    run <= 1'b0;
    wait (halt_seen);
    $display("Done: no errors");
    $finish;
  end

endmodule
